// ==== include/sampleBridge_defs.svh ====
// Sample bridge widths, FIFO depth, AXI4-Lite bus widths
// and the host register map
`ifndef SAMPLE_BRIDGE_DEFS_SVH
`define SAMPLE_BRIDGE_DEFS_SVH

// ====================
// Datapath
// ====================
`define SAMPLE_WIDTH 12      // Bits per sample
`define FIFO_DEPTH 16        // Power of 2, at least 4
`define DROP_WIDTH 8         // Drop counter, wraps

// ====================
// Host bus
// ====================
`define AXI_ADDR_WIDTH 4
`define AXI_DATA_WIDTH 32

// Register byte offsets
`define REG_CTRL 0           // Enable in bit 0
`define REG_STATUS 4         // Available, drop count
`define REG_DATA 8           // Pops one sample

`endif

// ==== logic/bridgeBusPkg.sv ====
// AXI4-Lite channel bundles and response codes for the host port
`include "sampleBridge_defs.svh"

package bridgeBusPkg;

    // Write address, data and response ready from the host
    typedef struct packed {
        logic                           awvalid;
        logic [`AXI_ADDR_WIDTH-1:0]     awaddr;
        logic                           wvalid;
        logic [`AXI_DATA_WIDTH-1:0]     wdata;
        logic [`AXI_DATA_WIDTH/8-1:0]   wstrb;    // Byte lanes
        logic                           bready;
    } axilWriteReq;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axilWriteRsp;

    // Read address and data ready from the host
    typedef struct packed {
        logic                       arvalid;
        logic [`AXI_ADDR_WIDTH-1:0] araddr;
        logic                       rready;
    } axilReadReq;

    typedef struct packed {
        logic                       arready;
        logic                       rvalid;
        logic [`AXI_DATA_WIDTH-1:0] rdata;
        logic [1:0]                 rresp;
    } axilReadRsp;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;   // Unmapped or read-only

endpackage

// ==== logic/bridgeFifoPkg.sv ====
// Sample word and sample beat types for the source side
`include "sampleBridge_defs.svh"

package bridgeFifoPkg;

    // ====================
    // Sample types
    // ====================

    // One raw sample as stored in the FIFO
    typedef logic [`SAMPLE_WIDTH-1:0] sampleWord;

    // Source beat, streamed on wclk with no ready
    typedef struct packed {
        logic      valid;     // Sample present this cycle
        sampleWord data;
    } sampleBeat;

endpackage

// ==== logic/asyncFifo.sv ====
// Dual-clock FIFO, asynchronous gray pointer compare,
// flags set at once and released through two flops
`timescale 1ns/100ps

module asyncFifo #(
    parameter int Width = 12,
    parameter int Size  = 16     // Power of 2, at least 4
) (
    // Read side
    input  logic             rclk,
    input  logic             aempty,     // Shared async reset
    input  logic             pop,
    output logic             rok,        // Not empty
    output logic [Width-1:0] popData,    // Head word, fall-through

    // Write side
    input  logic             wclk,
    input  logic             push,
    input  logic [Width-1:0] pushData,
    output logic             wok         // Not full
);
    localparam int N = $clog2(Size) - 1;  // Top pointer bit

    logic [Width-1:0] mem [Size];

    logic [N:0] rBin, rGray, rBinNext;
    logic [N:0] wBin, wGray, wBinNext;
    logic       rEmpty, rEmptyMeta, wFull, wFullMeta;
    logic       dir;                      // Set when heading toward full
    logic       emptyAsync, fullAsync, dirSet, dirClr;
    logic       rEmptySet, wFullSet;

    // ====================
    // Read side
    // ====================
    assign rBinNext = rBin + 1'b1;

    always_ff @(posedge rclk, posedge aempty) begin
        if (aempty) begin
            rBin  <= '0;
            rGray <= '0;
        end else if (pop && !rEmpty) begin
            rBin  <= rBinNext;
            rGray <= (rBinNext >> 1) ^ rBinNext;
        end
    end

    // Empty rises at once, falls after two rclk edges
    assign rEmptySet = emptyAsync | aempty;
    always_ff @(posedge rclk, posedge rEmptySet) begin
        if (rEmptySet) {rEmpty, rEmptyMeta} <= 2'b11;
        else           {rEmpty, rEmptyMeta} <= {rEmptyMeta, 1'b0};
    end

    assign popData = mem[rBin];
    assign rok     = !rEmpty;

    // ====================
    // Write side
    // ====================
    assign wBinNext = wBin + 1'b1;

    always_ff @(posedge wclk, posedge aempty) begin
        if (aempty) begin
            wBin  <= '0;
            wGray <= '0;
        end else if (push && !wFull) begin
            wBin  <= wBinNext;
            wGray <= (wBinNext >> 1) ^ wBinNext;
        end
    end

    always_ff @(posedge wclk) begin
        if (push && !wFull) mem[wBin] <= pushData;   // Storage, no reset
    end

    // Reset holds full so the source waits two wclk
    assign wFullSet = fullAsync | aempty;
    always_ff @(posedge wclk, posedge wFullSet) begin
        if (wFullSet) {wFull, wFullMeta} <= 2'b11;
        else          {wFull, wFullMeta} <= {wFullMeta, 1'b0};
    end

    assign wok = !wFull;

    // ====================
    // Async compare
    // ====================
    // Quadrant of write pointer relative to read pointer
    assign dirSet = (rGray[N] == wGray[N-1]) & (rGray[N-1] != wGray[N]);
    assign dirClr = ((rGray[N] != wGray[N-1]) & (rGray[N-1] == wGray[N])) | aempty;

    always_ff @(posedge dirClr, posedge dirSet) begin
        if (dirClr) dir <= 1'b0;
        else        dir <= 1'b1;
    end

    assign emptyAsync = (rGray == wGray) & !dir;
    assign fullAsync  = (rGray == wGray) & dir;

    // Callers must honour the flags
    popWhileEmpty: assert property (@(posedge rclk) disable iff (aempty) pop |-> !rEmpty);
    pushWhileFull: assert property (@(posedge wclk) disable iff (aempty) push |-> !wFull);

endmodule

// ==== logic/sampleIngress.sv ====
// Write-domain ingress: enable sync, FIFO push, gray-coded drop counter
`timescale 1ns/100ps
`include "sampleBridge_defs.svh"

module sampleIngress (
    input  logic                     wclk,
    input  logic                     aempty,
    input  logic                     enable,     // From rclk domain
    input  bridgeFifoPkg::sampleBeat sampleIn,
    input  logic                     wok,
    output logic                     push,
    output bridgeFifoPkg::sampleWord pushData,
    output logic [`DROP_WIDTH-1:0]   dropGray    // Crosses to rclk
);
    logic                   enMeta, enSync;
    logic                   drop;
    logic [`DROP_WIDTH-1:0] dropCount, dropNext;

    // ====================
    // Enable sync
    // ====================
    always_ff @(posedge wclk, posedge aempty) begin
        if (aempty) begin
            enMeta <= 1'b0;
            enSync <= 1'b0;
        end else begin
            enMeta <= enable;
            enSync <= enMeta;   // Effective two wclk later
        end
    end

    // ====================
    // Push and drop
    // ====================
    // No ready to the source, so a full FIFO means a lost sample
    assign push     = sampleIn.valid & enSync & wok;
    assign drop     = sampleIn.valid & enSync & !wok;
    assign pushData = sampleIn.data;          // Straight through

    assign dropNext = dropCount + 1'b1;

    // Binary count kept locally
    // Gray copy registered for the crossing
    always_ff @(posedge wclk, posedge aempty) begin
        if (aempty) begin
            dropCount <= '0;
            dropGray  <= '0;
        end else if (drop) begin
            dropCount <= dropNext;                  // Wraps
            dropGray  <= (dropNext >> 1) ^ dropNext;
        end
    end

    // Single-bit steps keep the rclk sampler coherent
    dropGrayStep: assert property (@(posedge wclk) disable iff (aempty)
        $countones(dropGray ^ $past(dropGray)) <= 1);

endmodule

// ==== logic/regControl.sv ====
// AXI4-Lite register slave: enable, status, FIFO data pop
// and drop-count sync from the write domain
`timescale 1ns/100ps
`include "sampleBridge_defs.svh"

module regControl (
    input  logic                       rclk,
    input  logic                       aempty,
    input  bridgeBusPkg::axilWriteReq  wrReq,
    output bridgeBusPkg::axilWriteRsp  wrRsp,
    input  bridgeBusPkg::axilReadReq   rdReq,
    output bridgeBusPkg::axilReadRsp   rdRsp,
    output logic                       enable,
    output logic                       pop,
    input  bridgeFifoPkg::sampleWord   popData,
    input  logic                       rok,
    input  logic [`DROP_WIDTH-1:0]     dropGray
);
    import bridgeBusPkg::*;

    localparam logic [`AXI_ADDR_WIDTH-1:0] CtrlAddr   = `REG_CTRL;
    localparam logic [`AXI_ADDR_WIDTH-1:0] StatusAddr = `REG_STATUS;
    localparam logic [`AXI_ADDR_WIDTH-1:0] DataAddr   = `REG_DATA;

    // Write channel state
    logic       wrAccept, bValid;
    logic [1:0] bResp;

    // Read channel state
    logic                       rdAccept, rValid;
    logic [`AXI_DATA_WIDTH-1:0] readWord, rData;
    logic [1:0]                 readResp, rResp;

    // Drop count crossing
    logic [`DROP_WIDTH-1:0] dropMeta, dropSync, dropCount;

    // ====================
    // Write channel
    // ====================
    // AW and W taken together, only with B free
    assign wrAccept = wrReq.awvalid & wrReq.wvalid & !bValid;

    always_ff @(posedge rclk, posedge aempty) begin
        if (aempty) begin
            bValid <= 1'b0;
            enable <= 1'b0;
        end else begin
            if (wrAccept) begin
                bValid <= 1'b1;
                // Only CTRL is writable
                if (wrReq.awaddr == CtrlAddr && wrReq.wstrb[0]) begin
                    enable <= wrReq.wdata[0];
                end
            end else if (bValid && wrReq.bready) begin
                bValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (wrAccept) bResp <= (wrReq.awaddr == CtrlAddr) ? respOkay : respSlvErr;
    end

    assign wrRsp = '{awready: wrAccept, wready: wrAccept, bvalid: bValid, bresp: bResp};

    // ====================
    // Read channel
    // ====================
    assign rdAccept = rdReq.arvalid & !rValid;
    assign pop      = rdAccept & (rdReq.araddr == DataAddr) & rok;   // Empty reads skip

    // Register decode
    always_comb begin
        readWord = '0;
        readResp = respOkay;
        case (rdReq.araddr)
            CtrlAddr:   readWord[0] = enable;
            StatusAddr: begin
                readWord[0]                = rok;
                readWord[8 +: `DROP_WIDTH] = dropCount;
            end
            DataAddr: begin
                if (rok) begin
                    readWord[`AXI_DATA_WIDTH-1]  = 1'b1;    // Valid flag
                    readWord[`SAMPLE_WIDTH-1:0] = popData;
                end
            end
            default:    readResp = respSlvErr;
        endcase
    end

    always_ff @(posedge rclk, posedge aempty) begin
        if (aempty)                       rValid <= 1'b0;
        else if (rdAccept)                rValid <= 1'b1;
        else if (rValid && rdReq.rready)  rValid <= 1'b0;
    end

    // Captured at the handshake, held through back-pressure
    always_ff @(posedge rclk) begin
        if (rdAccept) begin
            rData <= readWord;
            rResp <= readResp;
        end
    end

    assign rdRsp = '{arready: !rValid, rvalid: rValid, rdata: rData, rresp: rResp};

    // ====================
    // Drop count sync
    // ====================
    always_ff @(posedge rclk, posedge aempty) begin
        if (aempty) begin
            dropMeta <= '0;
            dropSync <= '0;
        end else begin
            dropMeta <= dropGray;
            dropSync <= dropMeta;
        end
    end

    // Gray to binary, each bit the XOR of all bits above it
    always_comb begin
        for (int i = 0; i < `DROP_WIDTH; i++) begin
            dropCount[i] = ^(dropSync >> i);
        end
    end

    // Held read beat must not move, so no pop slips in
    rDataHold: assert property (@(posedge rclk) disable iff (aempty)
        rValid && !rdReq.rready |=> rValid && $stable(rData) && $stable(rResp));

    // Every popped sample reaches the host as a valid word
    popReturnsSample: assert property (@(posedge rclk) disable iff (aempty)
        pop |=> rValid && rData[`AXI_DATA_WIDTH-1] && rResp == respOkay);

endmodule

// ==== logic/sampleBridge.sv ====
// Sample bridge top: register slave, write-domain ingress, async FIFO
`timescale 1ns/100ps
`include "sampleBridge_defs.svh"

module sampleBridge (
    input  logic                      rclk,
    input  logic                      wclk,
    input  logic                      aempty,
    input  bridgeBusPkg::axilWriteReq wrReq,
    output bridgeBusPkg::axilWriteRsp wrRsp,
    input  bridgeBusPkg::axilReadReq  rdReq,
    output bridgeBusPkg::axilReadRsp  rdRsp,
    input  bridgeFifoPkg::sampleBeat  sampleIn    // wclk domain
);
    import bridgeFifoPkg::*;

    logic                   enable;     // rclk domain
    logic                   push, wok;
    sampleWord              pushData;
    logic                   pop, rok;
    sampleWord              popData;
    logic [`DROP_WIDTH-1:0] dropGray;   // wclk domain

    // Host side
    regControl u_regControl (
        .rclk     (rclk),
        .aempty   (aempty),
        .wrReq    (wrReq),
        .wrRsp    (wrRsp),
        .rdReq    (rdReq),
        .rdRsp    (rdRsp),
        .enable   (enable),
        .pop      (pop),
        .popData  (popData),
        .rok      (rok),
        .dropGray (dropGray)
    );

    // Source side
    sampleIngress u_sampleIngress (
        .wclk     (wclk),
        .aempty   (aempty),
        .enable   (enable),
        .sampleIn (sampleIn),
        .wok      (wok),
        .push     (push),
        .pushData (pushData),
        .dropGray (dropGray)
    );

    // Clock crossing
    asyncFifo #(.Width(`SAMPLE_WIDTH), .Size(`FIFO_DEPTH)) u_asyncFifo (
        .rclk     (rclk),
        .aempty   (aempty),
        .pop      (pop),
        .rok      (rok),
        .popData  (popData),
        .wclk     (wclk),
        .push     (push),
        .pushData (pushData),
        .wok      (wok)
    );

endmodule

// ==== dv/sampleBridgeTb.sv ====
// Sample bridge testbench: clocks, LFSR sample source, AXI4-Lite host tasks,
// reference model with compare process and watchdog
`timescale 1ns/100ps
`include "sampleBridge_defs.svh"

module sampleBridgeTb;
    import bridgeBusPkg::*;
    import bridgeFifoPkg::*;

    localparam int  RclkPeriod          = 8;
    localparam real WclkPeriod          = 11.0;   // Source clock, unrelated to rclk
    localparam int  PlannedTransactions = 45;     // Bus accesses over all tests
    localparam int  PlannedSamples      = 43;
    localparam real TimeoutNs = PlannedTransactions * 200 * RclkPeriod
                              + PlannedSamples * 20 * WclkPeriod;

    logic        rclk = 1'b0;
    logic        wclk = 1'b0;
    logic        aempty;
    axilWriteReq wrReq;
    axilWriteRsp wrRsp;
    axilReadReq  rdReq;
    axilReadRsp  rdRsp;
    sampleBeat   sampleIn;

    // Model state
    logic                        modelEnable = 1'b0;
    sampleWord                   sampleQ[$];       // Accepted, not yet read
    logic [`DROP_WIDTH-1:0]      modelDrops = '0;
    logic [`AXI_DATA_WIDTH+1:0]  expRdQ[$];        // {rresp, rdata}
    logic [1:0]                  expWrQ[$];

    logic [31:0]                 lfsrState = 32'hca0f;
    int                          checks = 0;
    int                          errors = 0;

    always #(RclkPeriod / 2) rclk = ~rclk;
    always #(WclkPeriod / 2.0) wclk = ~wclk;

    sampleBridge u_sampleBridge (
        .rclk     (rclk),
        .wclk     (wclk),
        .aempty   (aempty),
        .wrReq    (wrReq),
        .wrRsp    (wrRsp),
        .rdReq    (rdReq),
        .rdRsp    (rdRsp),
        .sampleIn (sampleIn)
    );

    // ====================
    // Random source
    // ====================
    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // ====================
    // Reference model
    // ====================
    function automatic logic [`AXI_DATA_WIDTH+1:0] expectedRead(
        input logic [`AXI_ADDR_WIDTH-1:0] addr);
        logic [`AXI_DATA_WIDTH-1:0] word;
        logic [1:0]                 resp;
        word = '0;
        resp = respOkay;
        case (addr)
            `REG_CTRL:   word[0] = modelEnable;
            `REG_STATUS: begin
                word[0]    = (sampleQ.size() != 0);   // Available
                word[15:8] = modelDrops;
            end
            `REG_DATA: begin
                if (sampleQ.size() != 0) word = 32'h8000_0000 | sampleQ[0];
            end
            default:     resp = respSlvErr;           // Unmapped
        endcase
        return {resp, word};
    endfunction

    // Only CTRL accepts writes
    function automatic logic [1:0] expectedWriteResp(input logic [`AXI_ADDR_WIDTH-1:0] addr);
        return (addr == `REG_CTRL) ? respOkay : respSlvErr;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // ====================
    // Host bus tasks
    // ====================
    task automatic writeReg(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        expWrQ.push_back(expectedWriteResp(addr));
        if (addr == `REG_CTRL && strb[0]) modelEnable = data[0];
        @(posedge rclk);
        wrReq.awvalid <= 1'b1;
        wrReq.awaddr  <= addr;
        wrReq.wvalid  <= 1'b1;
        wrReq.wdata   <= data;
        wrReq.wstrb   <= strb;
        wrReq.bready  <= 1'b1;
        @(posedge rclk);
        while (!wrRsp.awready) @(posedge rclk);   // AW and W together
        checkValue("wready", wrRsp.wready, 1'b1);
        wrReq.awvalid <= 1'b0;
        wrReq.wvalid  <= 1'b0;
        @(posedge rclk);
        while (!wrRsp.bvalid) @(posedge rclk);
        wrReq.bready <= 1'b0;
    endtask

    // Stall holds rready low that many cycles after the handshake
    task automatic readReg(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int stall);
        expRdQ.push_back(expectedRead(addr));
        if (addr == `REG_DATA && sampleQ.size() != 0) void'(sampleQ.pop_front());
        @(posedge rclk);
        rdReq.arvalid <= 1'b1;
        rdReq.araddr  <= addr;
        rdReq.rready  <= (stall == 0);
        @(posedge rclk);
        while (!rdRsp.arready) @(posedge rclk);
        rdReq.arvalid <= 1'b0;
        if (stall > 0) begin
            repeat (stall) @(posedge rclk);
            rdReq.rready <= 1'b1;
        end
        @(posedge rclk);
        while (!(rdRsp.rvalid && rdReq.rready)) @(posedge rclk);
        rdReq.rready <= 1'b0;
    endtask

    // ====================
    // Sample source
    // ====================
    // Random gaps of 0 to 3 wclk, back to back when 0
    task automatic sendSamples(input int count);
        int        gap;
        sampleWord value;
        for (int i = 0; i < count; i++) begin
            gap = takeBits(2);
            repeat (gap) begin
                @(posedge wclk);
                sampleIn.valid <= 1'b0;
            end
            value = sampleWord'(takeBits(`SAMPLE_WIDTH));
            @(posedge wclk);
            sampleIn <= '{valid: 1'b1, data: value};
            if (modelEnable) begin
                if (sampleQ.size() < `FIFO_DEPTH) sampleQ.push_back(value);
                else modelDrops++;                  // Full, lost and counted
            end
        end
        @(posedge wclk);
        sampleIn.valid <= 1'b0;
    endtask

    // Compare every R and B beat with its queued expectation
    always @(posedge rclk) begin
        logic [`AXI_DATA_WIDTH+1:0] expRd;
        logic [1:0]                 expWr;
        if (!aempty && rdRsp.rvalid && rdReq.rready) begin
            if (expRdQ.size() == 0) begin
                errors++;
                $display("Read response at %0t ns with no read outstanding", $time);
            end else begin
                expRd = expRdQ.pop_front();
                checkValue("rdata", rdRsp.rdata, expRd[`AXI_DATA_WIDTH-1:0]);
                checkValue("rresp", rdRsp.rresp, expRd[`AXI_DATA_WIDTH+1 -: 2]);
            end
        end
        if (!aempty && wrRsp.bvalid && wrReq.bready) begin
            if (expWrQ.size() == 0) begin
                errors++;
                $display("Write response at %0t ns with no write outstanding", $time);
            end else begin
                expWr = expWrQ.pop_front();
                checkValue("bresp", wrRsp.bresp, expWr);
            end
        end
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired at %0t ns, the run stalled", $time);
        $display("Test failures found");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        aempty   = 1'b1;
        wrReq    = '0;
        rdReq    = '0;
        sampleIn = '0;
        repeat (2) @(posedge rclk);
        aempty <= 1'b0;
        repeat (2) @(posedge rclk);

        // Reset values
        readReg(`REG_CTRL, 0);
        readReg(`REG_STATUS, 0);
        readReg(`REG_DATA, 0);                      // Empty, zero word

        // Disabled source is ignored
        sendSamples(10);
        repeat (40) @(posedge wclk);
        readReg(`REG_STATUS, 0);

        // Enabled, ten samples in order
        writeReg(`REG_CTRL, 32'h1, 4'hf);
        repeat (4) @(posedge wclk);                 // Enable sync in wclk
        sendSamples(10);
        repeat (40) @(posedge wclk);
        readReg(`REG_STATUS, 0);
        repeat (11) readReg(`REG_DATA, 0);          // Last one finds it empty

        // Overflow, five drops
        sendSamples(`FIFO_DEPTH + 5);
        repeat (40) @(posedge wclk);
        readReg(`REG_STATUS, 0);
        repeat (`FIFO_DEPTH) readReg(`REG_DATA, 0);
        readReg(`REG_DATA, 0);
        readReg(`REG_STATUS, 0);

        // Back-pressure on R, no double pop
        sendSamples(2);
        repeat (40) @(posedge wclk);
        readReg(`REG_DATA, 6);
        readReg(`REG_DATA, 0);

        // Error responses
        writeReg(`REG_STATUS, 32'h1, 4'hf);
        writeReg(4'hc, 32'h1, 4'hf);
        readReg(4'hc, 0);

        // CTRL read back
        writeReg(`REG_CTRL, 32'h0, 4'hf);
        readReg(`REG_CTRL, 0);
        writeReg(`REG_CTRL, 32'h1, 4'h1);
        readReg(`REG_CTRL, 0);

        repeat (2) @(posedge rclk);                 // Let the last beat be compared
        if (expRdQ.size() != 0 || expWrQ.size() != 0) begin
            errors++;
            $display("Responses missing at the end: %0d read, %0d write",
                     expRdQ.size(), expWrQ.size());
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sampleBridge.f ====
+incdir+include
logic/bridgeBusPkg.sv
logic/bridgeFifoPkg.sv
logic/asyncFifo.sv
logic/sampleIngress.sv
logic/regControl.sv
logic/sampleBridge.sv
dv/sampleBridgeTb.sv
